// File: l2_front_top.f
+incdir+common
common/l2_pkg.sv
source/l2_req_tracker.sv
l2_front/l2_flush_walker.sv
l2_front/l2_input_decoder.sv
source/l2_front_top.sv
test/l2_front_sva_chk.sv
test/l2_front_monitor.sv
test/l2_front_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wall
TOP       = l2_front_tb
FILELIST  = l2_front_top.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Errors found" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf obj_dir $(LOG)

// File: test/l2_front_tests.txt
# name flush rsp fwd cpu rsp_addr fwd_addr cpu_addr fwd_stall stall_ended set_conflict evict
#   atomic hold | exp_op exp_tag exp_set exp_woff exp_boff exp_line exp_frep exp_crep walk
prio_rsp      0 1 1 1 ABCDEF1 0FEDCBA 12345678 0 0 0 0 0 0 1 ABCDEF 1 0 0 0       0 0 0
prio_fwd      0 0 1 1 ABCDEF1 0FEDCBA 12345678 0 0 0 0 0 0 2 0FEDCB A 0 0 0       0 0 0
prio_cpu      0 0 0 1 ABCDEF1 0FEDCBA 12345678 0 0 0 0 0 0 4 123456 7 2 0 1234567 0 0 0
flush_refused 1 0 0 1 ABCDEF1 0FEDCBA 12345678 0 0 0 0 0 0 4 123456 7 2 0 1234567 0 0 0
rsp_free_a    0 1 0 0 ABCDEF1 0FEDCBA 12345678 0 0 0 0 0 0 1 ABCDEF 1 0 0 0       0 0 0
rsp_free_b    0 1 0 0 ABCDEF1 0FEDCBA 12345678 0 0 0 0 0 0 1 ABCDEF 1 0 0 0       0 0 0
fwd_stalled   0 0 1 1 ABCDEF1 0FEDCBA 12345678 1 0 0 0 0 0 4 123456 7 2 0 1234567 0 0 0
fwd_replay    0 0 1 0 ABCDEF1 0FEDCBA 12345678 1 1 0 0 0 0 2 0FEDCB A 0 0 0       1 0 0
cpu_conflict  0 0 0 1 ABCDEF1 0FEDCBA 12345678 0 0 1 0 0 0 4 123456 7 2 0 1234567 0 1 0
evict_block   0 0 0 1 ABCDEF1 0FEDCBA 12345678 0 0 0 1 0 0 7 0      0 0 0 0       0 0 0
rsp_free_c    0 1 0 0 ABCDEF1 0FEDCBA 12345678 0 0 0 0 0 0 1 ABCDEF 1 0 0 0       0 0 0
rsp_free_d    0 1 0 0 ABCDEF1 0FEDCBA 12345678 0 0 0 0 0 0 1 ABCDEF 1 0 0 0       0 0 0
back_pressure 0 0 0 1 ABCDEF1 0FEDCBA 12345678 0 0 0 0 0 4 4 123456 7 2 0 1234567 0 0 0
rsp_free_e    0 1 0 0 ABCDEF1 0FEDCBA 12345678 0 0 0 0 0 0 1 ABCDEF 1 0 0 0       0 0 0
flush_walk    1 0 0 0 ABCDEF1 0FEDCBA 12345678 0 0 0 0 0 0 0 0      0 0 0 0       0 0 1

// File: test/l2_front_tb.sv
`timescale 1ns/100ps
`include "l2_consts.svh"

module l2_front_tb import l2_pkg::*; ();

    logic       clk, rst;
    logic       flush_valid, flush_ready, rsp_valid, rsp_ready;
    logic       fwd_valid, fwd_ready, cpu_valid, cpu_ready;
    line_addr_t rsp_addr, fwd_addr;
    addr_t      cpu_addr;
    logic       fwd_stall, fwd_stall_ended, set_conflict, evict_stall, ongoing_atomic;
    logic       dispatch_valid, dispatch_ready;
    l2_op_t     dispatch_op;
    l2_tag_t    line_tag, cpu_tag;
    l2_set_t    line_set, cpu_set, step_set;
    l2_way_t    step_way;
    line_addr_t cpu_line_addr;
    w_off_t     cpu_w_off;
    b_off_t     cpu_b_off;
    logic       fwd_replay, cpu_replay, flush_done;
    reqs_cnt_t  free_slots;

    integer      seed, fd, n;
    string       line, name;
    logic [31:0] f[22];

    l2_front_top u_dut (.*);

    l2_front_monitor u_mon (.*);

    bind l2_front_top l2_front_sva_chk u_sva (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic drop_inputs();
        flush_valid = 1'b0;
        rsp_valid = 1'b0;
        fwd_valid = 1'b0;
        cpu_valid = 1'b0;
        fwd_stall = 1'b0;
        fwd_stall_ended = 1'b0;
        set_conflict = 1'b0;
        evict_stall = 1'b0;
        ongoing_atomic = 1'b0;
    endtask

    task automatic run_test(input string tname, input logic [31:0] v[22]);
        logic got, done;
        int   i;
        @(negedge clk);
        u_mon.set_expect(tname, v[13], v[14], v[15], v[16], v[17], v[18], v[19], v[20]);
        {flush_valid, rsp_valid, fwd_valid, cpu_valid} = {v[0][0], v[1][0], v[2][0], v[3][0]};
        rsp_addr = v[4][27:0];
        fwd_addr = v[5][27:0];
        cpu_addr = v[6];
        {fwd_stall, fwd_stall_ended, set_conflict} = {v[7][0], v[8][0], v[9][0]};
        {evict_stall, ongoing_atomic} = {v[10][0], v[11][0]};
        dispatch_ready = (v[12] == 0);
        if (v[13] == 7) begin
            repeat (8) @(negedge clk);
            drop_inputs();
            u_mon.end_idle();
        end else begin
            got = 1'b0;
            for (i = 0; i < 50 && !got; i++) begin
                @(posedge clk);
                got = flush_ready | rsp_ready | fwd_ready | cpu_ready | fwd_replay | cpu_replay;
            end
            @(negedge clk);
            if (!got) begin
                drop_inputs();
                u_mon.note_failure(tname, "no input was accepted before the timeout");
            end else begin
                if (v[12] != 0) begin
                    rsp_valid = 1'b1; // new requests wait while the dispatch is held.
                    rsp_addr = ~rsp_addr;
                    cpu_addr = ~cpu_addr;
                end
                for (i = 0; i < int'(v[12]); i++) @(negedge clk);
                drop_inputs();
                dispatch_ready = 1'b1;
                done = 1'b0;
                for (i = 0; i < 50 && !done; i++) begin
                    @(negedge clk);
                    done = u_mon.test_done;
                end
                if (!done) u_mon.note_failure(tname, "the dispatch never arrived");
            end
        end
    endtask

    task automatic run_random();
        logic [31:0] v[22];
        logic [31:0] a;
        int          k;
        for (k = 0; k < 3; k++) begin
            a = $random(seed);
            v = '{default: 32'd0};
            v[3] = 1;
            v[6] = a;
            v[13] = 4;
            {v[14], v[15], v[16], v[17], v[18]} = {32'(a[31:8]), 32'(a[7:4]), 32'(a[3:2]),
                                                    32'(a[1:0]), 32'(a[31:4])};
            run_test($sformatf("rand_cpu_%0d", k), v);
            a = $random(seed);
            v = '{default: 32'd0};
            v[1] = 1;
            v[4] = {4'h0, a[27:0]}; // a line address has no offset bits.
            v[13] = 1;
            v[14] = 32'(a[27:4]);
            v[15] = 32'(a[3:0]);
            run_test($sformatf("rand_rsp_%0d", k), v);
        end
    endtask

    task automatic run_walk(input string tname);
        logic took;
        int   i, rsps;
        rsps = 0;
        u_mon.start_walk();
        for (i = 0; i < 3000 && !u_mon.walk_done_seen; i++) begin
            @(posedge clk);
            took = rsp_ready;
            @(negedge clk);
            if (took) begin
                rsp_valid = 1'b0;
                rsps++;
            end
            if (!rsp_valid && free_slots == 0) begin
                rsp_valid = 1'b1; // return one slot so the walk can go on.
                rsp_addr = line_addr_t'(i);
            end
        end
        for (i = 0; i < 20 && rsp_valid; i++) begin
            @(posedge clk);
            took = rsp_ready;
            @(negedge clk);
            if (took) begin
                rsp_valid = 1'b0;
                rsps++;
            end
        end
        repeat (3) @(negedge clk);
        if (!u_mon.walk_done_seen) begin
            u_mon.note_failure(tname, "the flush walk did not finish before the timeout");
        end else begin
            u_mon.end_walk(tname, rsps);
        end
    endtask

    initial begin
        seed = 19;
        rst = 1'b0;
        drop_inputs();
        rsp_addr = '0;
        fwd_addr = '0;
        cpu_addr = '0;
        dispatch_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        run_random();
        fd = $fopen("test/l2_front_tests.txt", "r");
        if (fd == 0) begin
            u_mon.note_failure("setup", "the test data file could not be opened");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") continue;
                n = $sscanf(line,
                            "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                            f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                            f[19], f[20], f[21]);
                if (n != 23) begin
                    u_mon.note_failure("parse", "a line of the test data file is malformed");
                    continue;
                end
                run_test(name, f);
                if (f[21] != 0) run_walk(name);
            end
            $fclose(fd);
        end
        repeat (3) @(negedge clk);
        u_mon.summary();
        if (u_mon.n_fail == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: test/l2_front_monitor.sv
`timescale 1ns/100ps
`include "l2_consts.svh"

module l2_front_monitor import l2_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       flush_ready,
    input logic       rsp_ready,
    input logic       fwd_ready,
    input logic       cpu_ready,
    input logic       fwd_replay,
    input logic       cpu_replay,
    input logic       dispatch_valid,
    input logic       dispatch_ready,
    input l2_op_t     dispatch_op,
    input l2_tag_t    line_tag,
    input l2_set_t    line_set,
    input line_addr_t cpu_line_addr,
    input l2_tag_t    cpu_tag,
    input l2_set_t    cpu_set,
    input w_off_t     cpu_w_off,
    input b_off_t     cpu_b_off,
    input l2_set_t    step_set,
    input l2_way_t    step_way,
    input logic       flush_done,
    input reqs_cnt_t  free_slots
);

    string       cur_name, fail_msg;
    logic [31:0] e_op, e_tag, e_set, e_woff, e_boff, e_line, e_frep, e_crep;
    logic        armed, test_done, ok, accept;
    logic        acc_prev, frep_prev, crep_prev, fwd_rdy_prev, cpu_rdy_prev;
    logic        walk_on, walk_ok, walk_done_seen;
    int          walk_set, walk_way, steps, done_cnt;
    int          n_pass, n_fail;

    initial begin
        armed = 1'b0;
        test_done = 1'b0;
        walk_on = 1'b0;
        acc_prev = 1'b0;
        n_pass = 0;
        n_fail = 0;
    end

    task automatic set_expect(input string name, input logic [31:0] op, tag, set, woff,
                              boff, line, frep, crep);
        cur_name = name;
        e_op = op;
        e_tag = tag;
        e_set = set;
        e_woff = woff;
        e_boff = boff;
        e_line = line;
        e_frep = frep;
        e_crep = crep;
        ok = 1'b1;
        test_done = 1'b0;
        armed = 1'b1;
    endtask

    task automatic cmp(input string field, input logic [31:0] exp, input logic [31:0] act);
        if (ok && exp != act) begin
            ok = 1'b0;
            fail_msg = $sformatf("FAILED %s: %s expected %h actual %h", cur_name, field, exp, act);
        end
    endtask

    task automatic finish_test();
        if (ok) begin
            n_pass++;
            $display("PASS %s", cur_name);
        end else begin
            n_fail++;
            $display("%s", fail_msg);
        end
        armed = 1'b0;
        test_done = 1'b1;
    endtask

    task automatic end_idle();
        finish_test();
    endtask

    task automatic note_failure(input string name, input string what);
        n_fail++;
        armed = 1'b0;
        $display("test %s failed: %s", name, what);
    endtask

    task automatic start_walk();
        walk_on = 1'b1;
        walk_ok = 1'b1;
        walk_done_seen = 1'b0;
        walk_set = 0;
        walk_way = 0;
        steps = 0;
        done_cnt = 0;
    endtask

    task automatic end_walk(input string name, input int rsps);
        walk_on = 1'b0;
        cur_name = name;
        ok = walk_ok;
        cmp("steps", 32'(`L2_SETS * `L2_WAYS), 32'(steps));
        cmp("flush_done pulses", 32'd1, 32'(done_cnt));
        cmp("free_slots", 32'(`N_REQS - steps + rsps), 32'(free_slots));
        finish_test();
    endtask

    task automatic summary();
        $display("tests %0d passed %0d failed %0d", n_pass + n_fail, n_pass, n_fail);
    endtask

    assign accept = flush_ready | rsp_ready | fwd_ready | cpu_ready | fwd_replay | cpu_replay;

    always @(posedge clk) begin
        if (rst) begin
            if (dispatch_valid && !dispatch_ready && accept) begin
                n_fail++;
                $display("an input was accepted while the dispatch was held");
            end
            if (armed && e_op == 7 && (accept || dispatch_valid) && ok) begin
                ok = 1'b0;
                fail_msg = $sformatf("test %s failed: a blocked request was dispatched",
                                     cur_name);
            end
            if (armed && e_op != 7 && acc_prev) begin
                if (!dispatch_valid) begin
                    ok = 1'b0;
                    fail_msg = $sformatf("test %s failed: no dispatch one cycle after accept",
                                         cur_name);
                end
                cmp("dispatch_op", e_op, 32'(dispatch_op));
                cmp("fwd_replay", e_frep, 32'(frep_prev));
                cmp("cpu_replay", e_crep, 32'(crep_prev));
                if (e_op == 2) cmp("fwd_ready", 32'(!e_frep), 32'(fwd_rdy_prev));
                if (e_op == 1 || e_op == 2) begin
                    cmp("line_tag", e_tag, 32'(line_tag));
                    cmp("line_set", e_set, 32'(line_set));
                end
                if (e_op == 4) begin
                    cmp("cpu_ready", 32'(!e_crep), 32'(cpu_rdy_prev));
                    cmp("cpu_tag", e_tag, 32'(cpu_tag));
                    cmp("cpu_set", e_set, 32'(cpu_set));
                    cmp("cpu_w_off", e_woff, 32'(cpu_w_off));
                    cmp("cpu_b_off", e_boff, 32'(cpu_b_off));
                    cmp("cpu_line_addr", e_line, 32'(cpu_line_addr));
                end
                finish_test();
            end
            if (walk_on) begin
                if (dispatch_valid && dispatch_op == op_flush_step) begin
                    if (walk_ok && (32'(step_set) != walk_set || 32'(step_way) != walk_way)) begin
                        walk_ok = 1'b0;
                        fail_msg = $sformatf("FAILED %s: set/way expected %h/%h actual %h/%h",
                                             cur_name, walk_set, walk_way, step_set, step_way);
                    end
                    steps++;
                    walk_way++;
                    if (walk_way == `L2_WAYS) begin
                        walk_way = 0; // next set starts at way 0.
                        walk_set++;
                    end
                end
                if (flush_done) begin
                    done_cnt++;
                    walk_done_seen = 1'b1;
                end
            end
            acc_prev = accept;
            frep_prev = fwd_replay;
            crep_prev = cpu_replay;
            fwd_rdy_prev = fwd_ready;
            cpu_rdy_prev = cpu_ready;
        end
    end

endmodule

// File: test/l2_front_sva_chk.sv
`timescale 1ns/100ps
`include "l2_consts.svh"

module l2_front_sva_chk import l2_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       flush_ready,
    input logic       rsp_ready,
    input logic       fwd_ready,
    input logic       cpu_ready,
    input logic       dispatch_valid,
    input logic       dispatch_ready,
    input l2_op_t     dispatch_op,
    input l2_tag_t    line_tag,
    input line_addr_t cpu_line_addr,
    input l2_set_t    step_set,
    input reqs_cnt_t  free_slots
);

    a_one_ready: assert property (@(posedge clk) disable iff (!rst)
        $onehot0({flush_ready, rsp_ready, fwd_ready, cpu_ready}))
        else $error("more than one input channel ready in a cycle");

    a_hold: assert property (@(posedge clk) disable iff (!rst)
        dispatch_valid && !dispatch_ready |=> dispatch_valid && $stable(dispatch_op) &&
        $stable(line_tag) && $stable(cpu_line_addr) && $stable(step_set))
        else $error("dispatch changed while held under back-pressure");

    a_slots: assert property (@(posedge clk) disable iff (!rst)
        free_slots <= reqs_cnt_t'(`N_REQS))
        else $error("free slot count above the number of slots");

endmodule

// File: source/l2_front_top.sv
`timescale 1ns/100ps

module l2_front_top import l2_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush_valid,
    output logic       flush_ready,
    input  logic       rsp_valid,
    output logic       rsp_ready,
    input  line_addr_t rsp_addr,
    input  logic       fwd_valid,
    output logic       fwd_ready,
    input  line_addr_t fwd_addr,
    input  logic       cpu_valid,
    output logic       cpu_ready,
    input  addr_t      cpu_addr,
    input  logic       fwd_stall,
    input  logic       fwd_stall_ended,
    input  logic       set_conflict,
    input  logic       evict_stall,
    input  logic       ongoing_atomic,
    output logic       dispatch_valid,
    input  logic       dispatch_ready,
    output l2_op_t     dispatch_op,
    output l2_tag_t    line_tag,
    output l2_set_t    line_set,
    output line_addr_t cpu_line_addr,
    output l2_tag_t    cpu_tag,
    output l2_set_t    cpu_set,
    output w_off_t     cpu_w_off,
    output b_off_t     cpu_b_off,
    output l2_set_t    step_set,
    output l2_way_t    step_way,
    output logic       fwd_replay,
    output logic       cpu_replay,
    output logic       flush_done,
    output reqs_cnt_t  free_slots
);

    logic    start_flush, incr_set, clr_way, clr_set, end_flush, flush_step;
    logic    alloc_slot, free_slot;
    logic    ongoing_flush;
    l2_set_t flush_set;
    l2_way_t flush_way;

    l2_input_decoder u_decoder (
        .clk, .rst,
        .flush_valid, .rsp_valid, .fwd_valid, .cpu_valid,
        .rsp_addr, .fwd_addr, .cpu_addr,
        .fwd_stall, .fwd_stall_ended, .set_conflict, .evict_stall, .ongoing_atomic,
        .reqs_cnt      (free_slots),
        .ongoing_flush, .flush_set, .flush_way,
        .dispatch_ready,
        .flush_ready, .rsp_ready, .fwd_ready, .cpu_ready,
        .dispatch_valid, .dispatch_op,
        .line_tag, .cpu_tag, .line_set, .cpu_set, .step_set, .step_way,
        .cpu_line_addr, .cpu_w_off, .cpu_b_off,
        .fwd_replay, .cpu_replay, .flush_done,
        .start_flush, .incr_set, .clr_way, .clr_set, .end_flush, .flush_step,
        .alloc_slot, .free_slot
    );

    l2_flush_walker u_walker (
        .clk, .rst,
        .start_flush, .incr_set, .clr_way, .clr_set, .end_flush,
        .step          (flush_step),
        .ongoing_flush, .flush_set, .flush_way
    );

    l2_req_tracker u_tracker (
        .clk, .rst,
        .alloc_slot, .free_slot,
        .reqs_cnt      (free_slots) // the count is shown directly on the port.
    );

endmodule

// File: l2_front/l2_input_decoder.sv
`timescale 1ns/100ps
`include "l2_consts.svh"

module l2_input_decoder import l2_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush_valid,
    input  logic       rsp_valid,
    input  logic       fwd_valid,
    input  logic       cpu_valid,
    input  line_addr_t rsp_addr,
    input  line_addr_t fwd_addr,
    input  addr_t      cpu_addr,
    input  logic       fwd_stall,
    input  logic       fwd_stall_ended,
    input  logic       set_conflict,
    input  logic       evict_stall,
    input  logic       ongoing_atomic,
    input  reqs_cnt_t  reqs_cnt,
    input  logic       ongoing_flush,
    input  l2_set_t    flush_set,
    input  l2_way_t    flush_way,
    input  logic       dispatch_ready,
    output logic       flush_ready,
    output logic       rsp_ready,
    output logic       fwd_ready,
    output logic       cpu_ready,
    output logic       dispatch_valid,
    output l2_op_t     dispatch_op,
    output l2_tag_t    line_tag,
    output l2_tag_t    cpu_tag,
    output l2_set_t    line_set,
    output l2_set_t    cpu_set,
    output l2_set_t    step_set,
    output l2_way_t    step_way,
    output line_addr_t cpu_line_addr,
    output w_off_t     cpu_w_off,
    output b_off_t     cpu_b_off,
    output logic       fwd_replay,
    output logic       cpu_replay,
    output logic       flush_done,
    output logic       start_flush,
    output logic       incr_set,
    output logic       clr_way,
    output logic       clr_set,
    output logic       end_flush,
    output logic       flush_step,
    output logic       alloc_slot,
    output logic       free_slot
);

    logic    decode_en;
    logic    do_flush, do_rsp, do_fwd, do_step, do_cpu;
    logic    dispatch_next;
    l2_op_t  op_next;
    l2_tag_t line_tag_next;
    l2_set_t line_set_next;

    assign decode_en = !dispatch_valid || dispatch_ready; // stage is empty or being taken.

    always_comb begin
        do_flush = 1'b0;
        do_rsp = 1'b0;
        do_fwd = 1'b0;
        do_step = 1'b0;
        do_cpu = 1'b0;
        fwd_replay = 1'b0;
        cpu_replay = 1'b0;
        incr_set = 1'b0;
        clr_way = 1'b0;
        clr_set = 1'b0;
        end_flush = 1'b0;
        op_next = dispatch_op;
        if (decode_en) begin
            if (flush_valid && reqs_cnt == reqs_cnt_t'(`N_REQS)) begin
                do_flush = 1'b1; // only with every slot free.
                op_next = op_flush;
            end else if (rsp_valid) begin
                do_rsp = 1'b1;
                op_next = op_rsp;
            end else if ((fwd_valid && !fwd_stall) || fwd_stall_ended) begin
                do_fwd = 1'b1;
                fwd_replay = fwd_stall;
                op_next = op_fwd;
            end else if (ongoing_flush) begin
                if (flush_set < `L2_SETS) begin
                    if (flush_way < `L2_WAYS) begin
                        if (!fwd_valid && reqs_cnt != '0) begin
                            do_step = 1'b1;
                            op_next = op_flush_step;
                        end
                    end else begin
                        incr_set = 1'b1; // last way done, nothing dispatched this cycle.
                        clr_way = 1'b1;
                    end
                end else begin
                    clr_set = 1'b1;
                    clr_way = 1'b1;
                    end_flush = 1'b1;
                end
            end else if ((cpu_valid || set_conflict) && !evict_stall &&
                         (reqs_cnt != '0 || ongoing_atomic)) begin
                do_cpu = 1'b1;
                cpu_replay = set_conflict;
                op_next = op_cpu_req;
            end
        end
    end

    assign flush_ready = do_flush;
    assign rsp_ready = do_rsp;
    assign fwd_ready = do_fwd && !fwd_stall; // a replayed forward was already taken.
    assign cpu_ready = do_cpu && !set_conflict;
    assign flush_done = end_flush;
    assign start_flush = do_flush;
    assign flush_step = do_step;
    assign alloc_slot = (do_cpu && !ongoing_atomic) || do_step;
    assign free_slot = do_rsp;
    assign dispatch_next = do_flush || do_rsp || do_fwd || do_step || do_cpu;

    always_comb begin
        if (do_rsp) begin
            line_tag_next = rsp_addr[`LINE_ADDR_BITS-1:`L2_SET_BITS];
            line_set_next = l2_set_t'(rsp_addr[`L2_SET_BITS-1:0]);
        end else if (do_fwd) begin
            line_tag_next = fwd_addr[`LINE_ADDR_BITS-1:`L2_SET_BITS];
            line_set_next = l2_set_t'(fwd_addr[`L2_SET_BITS-1:0]);
        end else begin
            line_tag_next = '0;
            line_set_next = '0;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dispatch_valid <= 1'b0;
            dispatch_op <= op_flush;
        end else if (decode_en) begin
            dispatch_valid <= dispatch_next;
            dispatch_op <= op_next;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_en) begin
            line_tag <= line_tag_next;
            line_set <= line_set_next;
            cpu_line_addr <= cpu_addr[`TAG_RANGE_HI:`SET_RANGE_LO];
            cpu_tag <= cpu_addr[`TAG_RANGE_HI:`L2_TAG_RANGE_LO];
            cpu_set <= l2_set_t'(cpu_addr[`L2_SET_RANGE_HI:`SET_RANGE_LO]);
            cpu_w_off <= cpu_addr[`W_OFF_RANGE_HI:`W_OFF_RANGE_LO];
            cpu_b_off <= cpu_addr[`B_OFF_RANGE_HI:`B_OFF_RANGE_LO];
            step_set <= flush_set; // counters advance on the same edge.
            step_way <= flush_way;
        end
    end

endmodule

// File: l2_front/l2_flush_walker.sv
`timescale 1ns/100ps

module l2_flush_walker import l2_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    start_flush,
    input  logic    incr_set,
    input  logic    clr_way,
    input  logic    clr_set,
    input  logic    end_flush,
    input  logic    step,
    output logic    ongoing_flush,
    output l2_set_t flush_set,
    output l2_way_t flush_way
);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ongoing_flush <= 1'b0;
        end else if (start_flush) begin
            ongoing_flush <= 1'b1;
        end else if (end_flush) begin
            ongoing_flush <= 1'b0;
        end
    end

    // set index walks 0 to L2_SETS, the last value marks the end of the walk.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flush_set <= '0;
        end else if (clr_set) begin
            flush_set <= '0;
        end else if (incr_set) begin
            flush_set <= flush_set + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flush_way <= '0;
        end else if (clr_way) begin
            flush_way <= '0;
        end else if (step) begin
            flush_way <= flush_way + 1'b1; // one way per dispatched step.
        end
    end

endmodule

// File: source/l2_req_tracker.sv
`timescale 1ns/100ps
`include "l2_consts.svh"

module l2_req_tracker import l2_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      alloc_slot,
    input  logic      free_slot,
    output reqs_cnt_t reqs_cnt
);

    reqs_cnt_t cnt_next;

    always_comb begin
        cnt_next = reqs_cnt;
        case ({alloc_slot, free_slot})
            2'b10: begin
                if (reqs_cnt != '0) begin
                    cnt_next = reqs_cnt - 1'b1;
                end
            end
            2'b01: begin
                if (reqs_cnt != reqs_cnt_t'(`N_REQS)) begin
                    cnt_next = reqs_cnt + 1'b1; // an unmatched response leaves it full.
                end
            end
            default: begin
                cnt_next = reqs_cnt; // both or neither cancel out.
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            reqs_cnt <= reqs_cnt_t'(`N_REQS);
        end else begin
            reqs_cnt <= cnt_next;
        end
    end

endmodule

// File: common/l2_pkg.sv
`include "l2_consts.svh"

package l2_pkg;

    typedef logic [`ADDR_BITS-1:0] addr_t;

    typedef logic [`LINE_ADDR_BITS-1:0] line_addr_t; // byte address without the offset.

    typedef logic [`L2_TAG_BITS-1:0] l2_tag_t;

    // one extra bit so the counters can reach L2_SETS and L2_WAYS.
    typedef logic [`L2_SET_BITS:0] l2_set_t;

    typedef logic [`L2_WAY_BITS:0] l2_way_t;

    typedef logic [`W_OFF_BITS-1:0] w_off_t;

    typedef logic [`B_OFF_BITS-1:0] b_off_t;

    typedef logic [`REQS_BITS:0] reqs_cnt_t; // counts 0 to N_REQS.

    typedef enum logic [2:0] {
        op_flush,
        op_rsp,
        op_fwd,
        op_flush_step,
        op_cpu_req
    } l2_op_t;

endpackage

// File: common/l2_consts.svh
`ifndef L2_CONSTS_SVH
`define L2_CONSTS_SVH

`define ADDR_BITS 32
`define OFFSET_BITS 4 // a line is 4 words of 4 bytes.
`define W_OFF_BITS 2
`define B_OFF_BITS 2
`define LINE_ADDR_BITS (`ADDR_BITS - `OFFSET_BITS)

`define L2_SET_BITS 4
`define L2_SETS 16
`define L2_TAG_BITS (`ADDR_BITS - `OFFSET_BITS - `L2_SET_BITS)

`define L2_WAY_BITS 2
`define L2_WAYS 4

`define REQS_BITS 2
`define N_REQS 4

// bit ranges of a full byte address.
`define TAG_RANGE_HI 31
`define L2_TAG_RANGE_LO 8
`define L2_SET_RANGE_HI 7
`define SET_RANGE_LO 4
`define W_OFF_RANGE_HI 3
`define W_OFF_RANGE_LO 2
`define B_OFF_RANGE_HI 1
`define B_OFF_RANGE_LO 0

`endif
